//--- bin_accumulator.sv
`timescale 1ns/100ps

module bin_accumulator
    import dft_bin_pkg::*;
#(
    parameter int MAX_LEN = 16
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  cplx_prod_t                                        prod,
    input  logic                                              prod_valid,
    input  logic                                              last,
    output logic signed [mult_width+$clog2(MAX_LEN)-1:0]      sum_re,
    output logic signed [mult_width+$clog2(MAX_LEN)-1:0]      sum_im,
    output logic                                              sum_valid
);

    localparam int acc_width = mult_width + $clog2(MAX_LEN);

    logic signed [acc_width-1:0] acc_re;
    logic signed [acc_width-1:0] acc_im;
    logic signed [acc_width-1:0] next_re;
    logic signed [acc_width-1:0] next_im;

    // sign extended add of the new product
    assign next_re = acc_re + acc_width'(prod.re);
    assign next_im = acc_im + acc_width'(prod.im);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_re    <= '0;
            acc_im    <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid && last;
            if (prod_valid) begin
                // restart at once so the next frame can follow directly
                if (last) begin
                    acc_re <= '0;
                    acc_im <= '0;
                end else begin
                    acc_re <= next_re;
                    acc_im <= next_im;
                end
            end
        end
    end

    // frame sum including the last product
    always_ff @(posedge clk) begin
        if (prod_valid && last) begin
            sum_re <= next_re;
            sum_im <= next_im;
        end
    end

endmodule

//--- complex_mult.sv
`timescale 1ns/100ps

module complex_mult
    import dft_bin_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  cplx_sample_t a,
    input  cplx_twidd_t  b,
    input  logic         in_valid,
    output cplx_prod_t   p,
    output logic         out_valid
);

    localparam int part_width = din_width + twidd_width;

    logic signed [part_width-1:0] rr;
    logic signed [part_width-1:0] ii;
    logic signed [part_width-1:0] ri;
    logic signed [part_width-1:0] ir;
    logic                         part_valid;

    // stage 1 registers the partial products
    always_ff @(posedge clk) begin
        rr <= part_width'(a.re) * part_width'(b.re);
        ii <= part_width'(a.im) * part_width'(b.im);
        ri <= part_width'(a.re) * part_width'(b.im);
        ir <= part_width'(a.im) * part_width'(b.re);
    end

    // stage 2 adds one bit so nothing wraps
    always_ff @(posedge clk) begin
        p.re <= mult_width'(rr) - mult_width'(ii);
        p.im <= mult_width'(ri) + mult_width'(ir);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            part_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            part_valid <= in_valid;
            out_valid  <= part_valid;
        end
    end

endmodule

//--- dft_bin.f
dft_bin_pkg.sv
lane_if.sv
sample_delay.sv
twiddle_table.sv
complex_mult.sv
bin_accumulator.sv
fixed_cast.sv
dft_bin_lane.sv
dft_bin.sv
dft_bin_assert.sv
tb_dft_bin.sv

//--- dft_bin.sv
`timescale 1ns/100ps

module dft_bin
    import dft_bin_pkg::*;
#(
    parameter int LANES       = 2,
    parameter int MAX_LEN     = 16,
    parameter int TWIDD_DELAY = 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [LANES*din_width-1:0]    din_re,
    input  logic [LANES*din_width-1:0]    din_im,
    input  logic                          din_valid,
    input  logic [$clog2(MAX_LEN)-1:0]    frame_last,
    input  logic                          twidd_we,
    input  logic [$clog2(MAX_LEN)-1:0]    twidd_waddr,
    input  logic [twidd_width-1:0]        twidd_wre,
    input  logic [twidd_width-1:0]        twidd_wim,
    output logic [LANES*dout_width-1:0]   dout_re,
    output logic [LANES*dout_width-1:0]   dout_im,
    output logic                          dout_valid,
    output logic                          cast_warning
);

    localparam int addr_width = $clog2(MAX_LEN);

    logic [LANES*din_width-1:0] din_re_r;
    logic [LANES*din_width-1:0] din_im_r;
    logic                       din_valid_r;
    logic [addr_width-1:0]      frame_last_r;
    cplx_twidd_t                twidd_wdata;
    cplx_twidd_t                twidd;
    logic                       twidd_valid;
    logic                       frame_end;
    cplx_out_t                  lane_y [LANES];
    logic [LANES-1:0]           lane_valid;
    logic [LANES-1:0]           lane_ovf;

    always_ff @(posedge clk) begin
        din_re_r     <= din_re;
        din_im_r     <= din_im;
        frame_last_r <= frame_last;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            din_valid_r <= 1'b0;
        end else begin
            din_valid_r <= din_valid;
        end
    end

    assign twidd_wdata = '{re: twidd_wre, im: twidd_wim};

    // shared by all lanes
    twiddle_table #(
        .MAX_LEN (MAX_LEN)
    ) u_twiddle_table (
        .clk         (clk),
        .rst         (rst),
        .we          (twidd_we),
        .waddr       (twidd_waddr),
        .wdata       (twidd_wdata),
        .rd_en       (din_valid_r),
        .frame_last  (frame_last_r),
        .twidd       (twidd),
        .twidd_valid (twidd_valid),
        .frame_end   (frame_end)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        cplx_sample_t sample_q;

        lane_if u_lane_if ();

        // one cycle to match the table read
        always_ff @(posedge clk) begin
            sample_q.re <= din_re_r[i*din_width +: din_width];
            sample_q.im <= din_im_r[i*din_width +: din_width];
        end

        assign u_lane_if.sample    = sample_q;
        assign u_lane_if.twiddle   = twidd;
        assign u_lane_if.valid     = twidd_valid;
        assign u_lane_if.frame_end = frame_end;

        dft_bin_lane #(
            .MAX_LEN     (MAX_LEN),
            .TWIDD_DELAY (TWIDD_DELAY)
        ) u_lane (
            .clk      (clk),
            .rst      (rst),
            .lane     (u_lane_if),
            .y        (lane_y[i]),
            .y_valid  (lane_valid[i]),
            .overflow (lane_ovf[i])
        );

        assign dout_re[i*dout_width +: dout_width] = lane_y[i].re;
        assign dout_im[i*dout_width +: dout_width] = lane_y[i].im;
    end

    // lanes run in lockstep
    assign dout_valid   = lane_valid[0];
    assign cast_warning = |lane_ovf;

endmodule

//--- dft_bin_assert.sv
`timescale 1ns/100ps

module dft_bin_assert #(
    parameter int ADDR_WIDTH = 4
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  dout_valid,
    input logic                  cast_warning,
    input logic [ADDR_WIDTH-1:0] frame_last
);

    // covers the reset cycles and the first cycle after
    a_quiet_after_reset: assert property (
        @(posedge clk) rst |=> !dout_valid
    ) else $error("dout_valid high during or right after reset");

    a_warning_with_valid: assert property (
        @(posedge clk) disable iff (rst) cast_warning |-> dout_valid
    ) else $error("cast_warning without dout_valid");

    // one result per frame, frames of one sample may follow each other
    a_single_pulse: assert property (
        @(posedge clk) disable iff (rst) dout_valid && (frame_last != '0) |=> !dout_valid
    ) else $error("dout_valid held for two cycles");

endmodule

//--- dft_bin_input.txt
# t name | w addr re im | a re im (every entry) | l frame_last | m gap_mode | r (reset)
# f n re0 im0 step_re0 step_im0 re1 im1 step_re1 step_im1 | e re0 im0 re1 im1 warn (hex)
t table
w 0 4000 0000
w 1 0000 c000
w 2 c000 0000
w 3 0000 4000
w 4 4000 0000
w 5 0000 c000
w 6 c000 0000
w 7 0000 4000
w 8 4000 0000
w 9 0000 c000
w a c000 0000
w b 0000 4000
w c 4000 0000
w d 0000 c000
w e c000 0000
w f 0000 4000
l f
t full_frame
f 10 03e8 07d0 0064 ffdb fe0c 012c ffec 0032
e fffffe08 00000448 ffffff10 fffffdd0 0
t short_frame
l 7
f 8 03e8 07d0 0064 ffdb fe0c 012c ffec 0032
e ffffff04 00000224 ffffff88 fffffee8 0
l f
t back_to_back
f 10 03e8 07d0 0064 ffdb fe0c 012c ffec 0032
e fffffe08 00000448 ffffff10 fffffdd0 0
f 10 03e8 07d0 0007 0003 fe0c 012c fff7 fff5
e ffffffb0 00000020 000000a0 00000010 0
t random_gaps
m 1
f 10 03e8 07d0 0064 ffdb fe0c 012c ffec 0032
e fffffe08 00000448 ffffff10 fffffdd0 0
f 10 03e8 07d0 0007 0003 fe0c 012c fff7 fff5
e ffffffb0 00000020 000000a0 00000010 0
m 0
t table_rewrite
w 0 2000 0000
f 10 0003 fffb 0064 ffdb fff9 0009 ffec 0032
e fffffe06 0000044a ffffff13 fffffdcb 0
w 0 4000 0000
t reset_mid_frame
f 5 03e8 07d0 0064 ffdb fe0c 012c ffec 0032
r
f 10 03e8 07d0 0064 ffdb fe0c 012c ffec 0032
e fffffe08 00000448 ffffff10 fffffdd0 0
# largest magnitude still fits 32 bits at this frame length, so no warning
t full_scale
a 8000 8000
f 10 8000 8000 0000 0000 0100 0000 0000 0000
e 00000000 00200000 ffffe000 ffffe000 0

//--- dft_bin_lane.sv
`timescale 1ns/100ps

module dft_bin_lane
    import dft_bin_pkg::*;
#(
    parameter int MAX_LEN     = 16,
    parameter int TWIDD_DELAY = 1
) (
    input  logic      clk,
    input  logic      rst,
    lane_if.sink      lane,
    output cplx_out_t y,
    output logic      y_valid,
    output logic      overflow
);

    localparam int acc_width    = mult_width + $clog2(MAX_LEN);
    localparam int mult_latency = 2;

    typedef struct packed {
        cplx_sample_t sample;
        cplx_twidd_t  twiddle;
    } pair_t;

    pair_t                       pair_in;
    pair_t                       pair_d;
    logic                        pair_valid;
    cplx_prod_t                  prod;
    logic                        prod_valid;
    logic                        end_flag;
    logic                        end_valid;
    logic signed [acc_width-1:0] sum_re;
    logic signed [acc_width-1:0] sum_im;
    logic                        sum_valid;

    assign pair_in = '{sample: lane.sample, twiddle: lane.twiddle};

    sample_delay #(
        .T     (pair_t),
        .DEPTH (TWIDD_DELAY)
    ) u_pair_delay (
        .clk        (clk),
        .rst        (rst),
        .din        (pair_in),
        .din_valid  (lane.valid),
        .dout       (pair_d),
        .dout_valid (pair_valid)
    );

    complex_mult u_mult (
        .clk       (clk),
        .rst       (rst),
        .a         (pair_d.sample),
        .b         (pair_d.twiddle),
        .in_valid  (pair_valid),
        .p         (prod),
        .out_valid (prod_valid)
    );

    // frame end rides along to meet the product
    sample_delay #(
        .T     (logic),
        .DEPTH (TWIDD_DELAY + mult_latency)
    ) u_end_delay (
        .clk        (clk),
        .rst        (rst),
        .din        (lane.frame_end),
        .din_valid  (lane.valid),
        .dout       (end_flag),
        .dout_valid (end_valid)
    );

    bin_accumulator #(
        .MAX_LEN (MAX_LEN)
    ) u_acc (
        .clk        (clk),
        .rst        (rst),
        .prod       (prod),
        .prod_valid (prod_valid),
        .last       (end_flag && end_valid),
        .sum_re     (sum_re),
        .sum_im     (sum_im),
        .sum_valid  (sum_valid)
    );

    fixed_cast #(
        .MAX_LEN (MAX_LEN)
    ) u_cast (
        .clk       (clk),
        .rst       (rst),
        .sum_re    (sum_re),
        .sum_im    (sum_im),
        .in_valid  (sum_valid),
        .y         (y),
        .out_valid (y_valid),
        .overflow  (overflow)
    );

endmodule

//--- dft_bin_pkg.sv
package dft_bin_pkg;

    // input samples, Q1.15
    localparam int din_width = 16;
    localparam int din_point = 15;

    // twiddle factors, Q2.14
    localparam int twidd_width = 16;
    localparam int twidd_point = 14;

    // full precision complex product
    localparam int mult_width = din_width + twidd_width + 1;
    localparam int mult_point = din_point + twidd_point;

    localparam int dout_width = 32;
    localparam int dout_point = 15;

    typedef struct packed {
        logic signed [din_width-1:0] re;
        logic signed [din_width-1:0] im;
    } cplx_sample_t;

    typedef struct packed {
        logic signed [twidd_width-1:0] re;
        logic signed [twidd_width-1:0] im;
    } cplx_twidd_t;

    typedef struct packed {
        logic signed [mult_width-1:0] re;
        logic signed [mult_width-1:0] im;
    } cplx_prod_t;

    typedef struct packed {
        logic signed [dout_width-1:0] re;
        logic signed [dout_width-1:0] im;
    } cplx_out_t;

endpackage

//--- fixed_cast.sv
`timescale 1ns/100ps

module fixed_cast
    import dft_bin_pkg::*;
#(
    parameter int MAX_LEN = 16
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic signed [mult_width+$clog2(MAX_LEN)-1:0] sum_re,
    input  logic signed [mult_width+$clog2(MAX_LEN)-1:0] sum_im,
    input  logic                                         in_valid,
    output cplx_out_t                                    y,
    output logic                                         out_valid,
    output logic                                         overflow
);

    localparam int acc_width = mult_width + $clog2(MAX_LEN);
    localparam int shift     = mult_point - dout_point;
    localparam int sh_width  = acc_width - shift;
    localparam int cmp_width = (sh_width > dout_width) ? sh_width : dout_width;

    localparam logic signed [dout_width-1:0] max_out = {1'b0, {(dout_width-1){1'b1}}};
    localparam logic signed [dout_width-1:0] min_out = {1'b1, {(dout_width-1){1'b0}}};

    // floor shift and clip, msb of the result is the overflow bit
    function automatic logic [dout_width:0] cast_one(input logic signed [acc_width-1:0] v);
        logic signed [cmp_width-1:0] sh;
        sh = cmp_width'(v >>> shift);
        if (sh > max_out) begin
            return {1'b1, max_out};
        end else if (sh < min_out) begin
            return {1'b1, min_out};
        end
        return {1'b0, sh[dout_width-1:0]};
    endfunction

    logic [dout_width:0] cast_re;
    logic [dout_width:0] cast_im;

    assign cast_re = cast_one(sum_re);
    assign cast_im = cast_one(sum_im);

    always_ff @(posedge clk) begin
        y.re <= cast_re[dout_width-1:0];
        y.im <= cast_im[dout_width-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            out_valid <= in_valid;
            overflow  <= in_valid && (cast_re[dout_width] || cast_im[dout_width]);
        end
    end

endmodule

//--- lane_if.sv
`timescale 1ns/100ps

// aligned sample and twiddle for one lane
interface lane_if
    import dft_bin_pkg::*;
();

    cplx_sample_t sample;
    cplx_twidd_t  twiddle;
    logic         valid;
    // only meaningful with valid
    logic         frame_end;

    modport source (
        output sample,
        output twiddle,
        output valid,
        output frame_end
    );

    modport sink (
        input sample,
        input twiddle,
        input valid,
        input frame_end
    );

endinterface

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f dft_bin.f --top-module tb_dft_bin -o sim_dft_bin

status=0
./obj_dir/sim_dft_bin > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- sample_delay.sv
`timescale 1ns/100ps

module sample_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  T     din,
    input  logic din_valid,
    output T     dout,
    output logic dout_valid
);

    generate
        if (DEPTH == 0) begin : g_bypass
            assign dout       = din;
            assign dout_valid = din_valid;
        end else begin : g_shift
            T           data_q [DEPTH];
            logic [DEPTH-1:0] valid_q;

            always_ff @(posedge clk) begin
                data_q[0] <= din;
                for (int i = 1; i < DEPTH; i++) begin
                    data_q[i] <= data_q[i-1];
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    valid_q <= '0;
                end else begin
                    valid_q[0] <= din_valid;
                    for (int i = 1; i < DEPTH; i++) begin
                        valid_q[i] <= valid_q[i-1];
                    end
                end
            end

            assign dout       = data_q[DEPTH-1];
            assign dout_valid = valid_q[DEPTH-1];
        end
    endgenerate

endmodule

//--- tb_dft_bin.sv
`timescale 1ns/100ps

module tb_dft_bin
    import dft_bin_pkg::*;
();

    localparam int lanes       = 2;
    localparam int max_len     = 16;
    localparam int twidd_delay = 1;
    localparam int addr_width  = $clog2(max_len);
    localparam int timeout     = 100;

    logic                          clk;
    logic                          rst;
    logic [lanes*din_width-1:0]    din_re;
    logic [lanes*din_width-1:0]    din_im;
    logic                          din_valid;
    logic [addr_width-1:0]         frame_last;
    logic                          twidd_we;
    logic [addr_width-1:0]         twidd_waddr;
    logic [twidd_width-1:0]        twidd_wre;
    logic [twidd_width-1:0]        twidd_wim;
    logic [lanes*dout_width-1:0]   dout_re;
    logic [lanes*dout_width-1:0]   dout_im;
    logic                          dout_valid;
    logic                          cast_warning;

    // warn bit above lane 1 above lane 0
    logic [2*$bits(cplx_out_t):0] exp_q [$];
    string                        name_q [$];
    string                        test_name = "none";
    logic [7:0]                   lfsr = 8'd13;
    logic                         gap_mode = 1'b0;
    int                           check_count = 0;
    int                           value_errors = 0;
    int                           other_errors = 0;
    logic [31:0]                  v [9];

    dft_bin #(
        .LANES       (lanes),
        .MAX_LEN     (max_len),
        .TWIDD_DELAY (twidd_delay)
    ) u_dft_bin (.*);

    bind dft_bin dft_bin_assert #(
        .ADDR_WIDTH (addr_width)
    ) u_dft_bin_assert (
        .clk          (clk),
        .rst          (rst),
        .dout_valid   (dout_valid),
        .cast_warning (cast_warning),
        .frame_last   (frame_last_r)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^8 + x^6 + x^5 + x^4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_bits(input int n, output int bits);
        bits = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = (bits << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_out(input string name, input int lane, input cplx_out_t expv,
                             input cplx_out_t actv);
        check_count++;
        if (actv !== expv) begin
            $display("FAILED %s lane %0d: expected re %0d im %0d, actual re %0d im %0d",
                     name, lane, expv.re, expv.im, actv.re, actv.im);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expv, input logic actv);
        check_count++;
        if (actv !== expv) begin
            $display("FAILED %s cast_warning: expected %b, actual %b", name, expv, actv);
            value_errors++;
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout: %s", what);
        other_errors++;
        $display("checks %0d, value errors %0d, other errors %0d",
                 check_count, value_errors, other_errors);
        $display("Errors found");
        $finish;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        din_valid <= 1'b0;
        twidd_we  <= 1'b0;
    endtask

    task automatic write_twiddle(input logic [addr_width-1:0] addr,
                                 input logic [15:0] re, input logic [15:0] im);
        @(posedge clk);
        din_valid   <= 1'b0;
        twidd_we    <= 1'b1;
        twidd_waddr <= addr;
        twidd_wre   <= re;
        twidd_wim   <= im;
    endtask

    task automatic set_frame_last(input logic [addr_width-1:0] last);
        @(posedge clk);
        din_valid  <= 1'b0;
        twidd_we   <= 1'b0;
        frame_last <= last;
    endtask

    // sample k of lane l is base + k * step in each component
    task automatic drive_frame();
        int          gaps;
        logic [15:0] k16;
        for (int k = 0; k < int'(v[0]); k++) begin
            if (gap_mode) begin
                take_bits(2, gaps);
                repeat (gaps) idle_cycle();
            end
            k16 = 16'(k);
            @(posedge clk);
            din_valid <= 1'b1;
            twidd_we  <= 1'b0;
            din_re    <= {v[5][15:0] + v[7][15:0] * k16, v[1][15:0] + v[3][15:0] * k16};
            din_im    <= {v[6][15:0] + v[8][15:0] * k16, v[2][15:0] + v[4][15:0] * k16};
        end
    endtask

    task automatic drain();
        int count;
        count = 0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            count++;
            if (count > timeout) begin
                fail_timeout("pending results never arrived");
            end
        end
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst       <= 1'b1;
        din_valid <= 1'b0;
        twidd_we  <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    endtask

    // outputs sampled mid cycle
    initial begin
        logic [2*$bits(cplx_out_t):0] e;
        string                        name;
        cplx_out_t                    act0;
        cplx_out_t                    act1;
        int                           wait_count;
        wait_count = 0;
        forever begin
            @(negedge clk);
            if (dout_valid) begin
                if (exp_q.size() == 0) begin
                    $display("a result came out while no frame was pending");
                    other_errors++;
                end else begin
                    e    = exp_q.pop_front();
                    name = name_q.pop_front();
                    act0 = '{re: dout_re[31:0], im: dout_im[31:0]};
                    act1 = '{re: dout_re[63:32], im: dout_im[63:32]};
                    check_out(name, 0, e[63:0], act0);
                    check_out(name, 1, e[127:64], act1);
                    check_flag(name, e[128], cast_warning);
                end
                wait_count = 0;
            end else if (exp_q.size() > 0) begin
                wait_count++;
                if (wait_count > timeout) begin
                    fail_timeout("dout_valid did not rise for a finished frame");
                end
            end
        end
    end

    initial begin
        int    fd;
        string line;
        string cmd;
        rst         = 1'b1;
        din_re      = '0;
        din_im      = '0;
        din_valid   = 1'b0;
        frame_last  = addr_width'(max_len - 1);
        twidd_we    = 1'b0;
        twidd_waddr = '0;
        twidd_wre   = '0;
        twidd_wim   = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("dft_bin_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open dft_bin_input.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cmd  = "";
                void'($fgets(line, fd));
                void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h", cmd,
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]));
                if (cmd.len() == 0 || cmd.getc(0) == "#") begin
                    continue;
                end
                case (cmd)
                    "t": void'($sscanf(line, "%s %s", cmd, test_name));
                    "w": write_twiddle(v[0][addr_width-1:0], v[1][15:0], v[2][15:0]);
                    "a": begin
                        for (int i = 0; i < max_len; i++) begin
                            write_twiddle(addr_width'(i), v[0][15:0], v[1][15:0]);
                        end
                    end
                    "l": set_frame_last(v[0][addr_width-1:0]);
                    "m": gap_mode = v[0][0];
                    "f": drive_frame();
                    "e": begin
                        exp_q.push_back({v[4][0], v[2], v[3], v[0], v[1]});
                        name_q.push_back(test_name);
                    end
                    "r": begin
                        drain();
                        do_reset();
                    end
                    default: begin
                        $display("unknown command in data file: %s", cmd);
                        other_errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        idle_cycle();
        drain();
        // catch any stray result
        repeat (20) @(posedge clk);
        $display("checks %0d, value errors %0d, other errors %0d",
                 check_count, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- twiddle_table.sv
`timescale 1ns/100ps

module twiddle_table
    import dft_bin_pkg::*;
#(
    parameter int MAX_LEN = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we,
    input  logic [$clog2(MAX_LEN)-1:0] waddr,
    input  cplx_twidd_t                wdata,
    input  logic                       rd_en,
    input  logic [$clog2(MAX_LEN)-1:0] frame_last,
    output cplx_twidd_t                twidd,
    output logic                       twidd_valid,
    output logic                       frame_end
);

    localparam int addr_width = $clog2(MAX_LEN);

    cplx_twidd_t           mem [MAX_LEN];
    logic [addr_width-1:0] pos;

    // a read in the same cycle still sees the old data
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        twidd <= mem[pos];
    end

    // frame position
    always_ff @(posedge clk) begin
        if (rst) begin
            pos         <= '0;
            twidd_valid <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            twidd_valid <= rd_en;
            frame_end   <= rd_en && (pos == frame_last);
            if (rd_en) begin
                if (pos == frame_last) begin
                    pos <= '0;
                end else begin
                    pos <= pos + addr_width'(1);
                end
            end
        end
    end

endmodule
